// File: source/rnn_pkg.sv
`default_nettype none

package rnn_pkg;

    localparam int DEF_VOCAB_SIZE = 76;
    localparam int DEF_EMBED_SIZE = 4;
    localparam int DEF_HIDDEN_SIZE = 8;

    localparam int DATA_WIDTH = 16;  // Q8.8 word
    localparam int FRAC_BITS = 8;
    localparam int ADDR_WIDTH = 27;

    typedef enum logic [3:0] {
        S_IDLE,
        S_EMB_REQ,
        S_EMB_WAIT,
        S_NEURON_START,
        S_HH_REQ,
        S_HH_WAIT,
        S_HHB_REQ,
        S_HHB_WAIT,
        S_IH_REQ,
        S_IH_WAIT,
        S_IHB_REQ,
        S_IHB_WAIT,
        S_STORE,
        S_COMMIT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        FETCH_EMBED,
        FETCH_W_IH,
        FETCH_W_HH,
        FETCH_B_IH,
        FETCH_B_HH
    } fetch_kind_t;

    // Index width able to hold 0 .. max(a, b) - 1
    function automatic int idx_width(int a, int b = 1);
        int n;
        n = (a > b) ? a : b;
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

// File: source/weight_address_gen.sv
`default_nettype none

module weight_address_gen #(
    parameter int VOCAB_SIZE = rnn_pkg::DEF_VOCAB_SIZE,
    parameter int EMBED_SIZE = rnn_pkg::DEF_EMBED_SIZE,
    parameter int HIDDEN_SIZE = rnn_pkg::DEF_HIDDEN_SIZE
) (
    input  logic clk,
    input  logic reset,
    input  rnn_pkg::fetch_kind_t fetch_kind,
    input  logic [rnn_pkg::idx_width(VOCAB_SIZE)-1:0] token,
    input  logic [rnn_pkg::idx_width(HIDDEN_SIZE)-1:0] neuron_idx,
    input  logic [rnn_pkg::idx_width(HIDDEN_SIZE, EMBED_SIZE)-1:0] inner_idx,
    output logic [rnn_pkg::ADDR_WIDTH-1:0] mem_addr
);
    import rnn_pkg::*;

    localparam int TOK_W = idx_width(VOCAB_SIZE);

    // Region bases in words
    localparam int W_IH_BASE = VOCAB_SIZE * EMBED_SIZE;
    localparam int W_HH_BASE = W_IH_BASE + HIDDEN_SIZE * EMBED_SIZE;
    localparam int B_IH_BASE = W_HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int B_HH_BASE = B_IH_BASE + HIDDEN_SIZE;

    logic [TOK_W-1:0] token_q;
    logic [TOK_W-1:0] token_sel;
    logic first_embed;
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] row;
    logic [ADDR_WIDTH-1:0] row_len;
    logic [ADDR_WIDTH-1:0] col;

    assign first_embed = (fetch_kind == FETCH_EMBED) && (inner_idx == '0);
    assign token_sel = first_embed ? token : token_q;

    always_comb
    begin
        base = '0;
        row = ADDR_WIDTH'(neuron_idx);
        row_len = 'd1;
        col = '0;
        case (fetch_kind)
            FETCH_EMBED:
            begin
                row = ADDR_WIDTH'(token_sel);
                row_len = ADDR_WIDTH'(EMBED_SIZE);
                col = ADDR_WIDTH'(inner_idx);
            end
            FETCH_W_IH:
            begin
                base = ADDR_WIDTH'(W_IH_BASE);
                row_len = ADDR_WIDTH'(EMBED_SIZE);
                col = ADDR_WIDTH'(inner_idx);
            end
            FETCH_W_HH:
            begin
                base = ADDR_WIDTH'(W_HH_BASE);
                row_len = ADDR_WIDTH'(HIDDEN_SIZE);
                col = ADDR_WIDTH'(inner_idx);
            end
            FETCH_B_IH: base = ADDR_WIDTH'(B_IH_BASE);
            FETCH_B_HH: base = ADDR_WIDTH'(B_HH_BASE);
            default:    base = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_addr <= '0;
            token_q <= '0;
        end
        else
        begin
            mem_addr <= base + row * row_len + col;
            if (first_embed)
                token_q <= token;  // Held for the rest of the embedding row
        end
    end

endmodule

`default_nettype wire

// File: source/mac_unit.sv
`default_nettype none

module mac_unit (
    input  logic clk,
    input  logic reset,
    input  logic acc_clear,
    input  logic acc_mul,
    input  logic acc_add,
    input  logic signed [rnn_pkg::DATA_WIDTH-1:0] mem_data,
    input  logic signed [rnn_pkg::DATA_WIDTH-1:0] operand,
    output logic signed [rnn_pkg::DATA_WIDTH-1:0] acc
);
    import rnn_pkg::*;

    logic signed [2*DATA_WIDTH-1:0] product;
    logic signed [DATA_WIDTH-1:0] scaled;

    assign product = mem_data * operand;
    // Arithmetic shift by the fraction, then keep the low word
    assign scaled = product[FRAC_BITS +: DATA_WIDTH];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            acc <= '0;
        end
        else if (acc_clear)
        begin
            acc <= '0;
        end
        else if (acc_mul)
        begin
            acc <= acc + scaled;  // Wraps at 16 bits
        end
        else if (acc_add)
        begin
            acc <= acc + mem_data;
        end
    end

    a_ctrl_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({acc_clear, acc_mul, acc_add}))
        else $error("more than one accumulator control active");

endmodule

`default_nettype wire

// File: source/state_registers.sv
`default_nettype none

module state_registers #(
    parameter int EMBED_SIZE = rnn_pkg::DEF_EMBED_SIZE,
    parameter int HIDDEN_SIZE = rnn_pkg::DEF_HIDDEN_SIZE
) (
    input  logic clk,
    input  logic reset,
    input  logic emb_write,
    input  logic store,
    input  logic commit,
    input  rnn_pkg::fetch_kind_t fetch_kind,
    input  logic [rnn_pkg::idx_width(HIDDEN_SIZE)-1:0] neuron_idx,
    input  logic [rnn_pkg::idx_width(HIDDEN_SIZE, EMBED_SIZE)-1:0] inner_idx,
    input  logic signed [rnn_pkg::DATA_WIDTH-1:0] mem_data,
    input  logic signed [rnn_pkg::DATA_WIDTH-1:0] acc,
    input  logic [rnn_pkg::idx_width(HIDDEN_SIZE)-1:0] hidden_index,
    output logic signed [rnn_pkg::DATA_WIDTH-1:0] operand,
    output logic signed [rnn_pkg::DATA_WIDTH-1:0] hidden_value
);
    import rnn_pkg::*;

    localparam int EMB_W = idx_width(EMBED_SIZE);
    localparam int HID_W = idx_width(HIDDEN_SIZE);

    logic signed [DATA_WIDTH-1:0] embedding [EMBED_SIZE];
    logic signed [DATA_WIDTH-1:0] new_hidden [HIDDEN_SIZE];
    logic signed [DATA_WIDTH-1:0] old_hidden [HIDDEN_SIZE];
    logic [EMB_W-1:0] emb_idx;
    logic [HID_W-1:0] hid_idx;

    assign emb_idx = inner_idx[EMB_W-1:0];
    assign hid_idx = inner_idx[HID_W-1:0];

    // W_ih pairs with the embedding, everything else with the old state
    assign operand = (fetch_kind == FETCH_W_IH) ? embedding[emb_idx] : old_hidden[hid_idx];
    assign hidden_value = old_hidden[hidden_index];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            embedding <= '{default: '0};
            new_hidden <= '{default: '0};
            old_hidden <= '{default: '0};
        end
        else
        begin
            if (emb_write)
                embedding[emb_idx] <= mem_data;
            if (store)
                new_hidden[neuron_idx] <= acc;
            if (commit)
                old_hidden <= new_hidden;  // Whole vector at once
        end
    end

    a_index_range: assert property (@(posedge clk) disable iff (reset)
        int'(hidden_index) < HIDDEN_SIZE)
        else $error("hidden_index out of range");

endmodule

`default_nettype wire

// File: source/rnn_control.sv
`default_nettype none

module rnn_control #(
    parameter int EMBED_SIZE = rnn_pkg::DEF_EMBED_SIZE,
    parameter int HIDDEN_SIZE = rnn_pkg::DEF_HIDDEN_SIZE
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic mem_valid,
    output logic busy,
    output logic done,
    output logic mem_req,
    output rnn_pkg::fetch_kind_t fetch_kind,
    output logic [rnn_pkg::idx_width(HIDDEN_SIZE)-1:0] neuron_idx,
    output logic [rnn_pkg::idx_width(HIDDEN_SIZE, EMBED_SIZE)-1:0] inner_idx,
    output logic acc_clear,
    output logic acc_mul,
    output logic acc_add,
    output logic emb_write,
    output logic store,
    output logic commit
);
    import rnn_pkg::*;

    localparam int HID_W = idx_width(HIDDEN_SIZE);
    localparam int INNER_W = idx_width(HIDDEN_SIZE, EMBED_SIZE);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic [HID_W-1:0] neuron_q;
    logic [INNER_W-1:0] inner_q;
    logic read_pending;
    logic req_state;
    logic inner_step;
    logic emb_last;
    logic hid_last;
    logic neuron_last;

    assign emb_last = (inner_q == INNER_W'(EMBED_SIZE - 1));
    assign hid_last = (inner_q == INNER_W'(HIDDEN_SIZE - 1));
    assign neuron_last = (neuron_q == HID_W'(HIDDEN_SIZE - 1));

    assign req_state = (state == S_EMB_REQ) || (state == S_HH_REQ) || (state == S_HHB_REQ) ||
                       (state == S_IH_REQ) || (state == S_IHB_REQ);
    assign inner_step = mem_valid &&
                        ((state == S_EMB_WAIT) || (state == S_HH_WAIT) || (state == S_IH_WAIT));

    assign busy = (state != S_IDLE);
    assign neuron_idx = neuron_q;
    assign inner_idx = inner_q;
    assign acc_clear = (state == S_NEURON_START);
    assign acc_mul = mem_valid && ((state == S_HH_WAIT) || (state == S_IH_WAIT));
    assign acc_add = mem_valid && ((state == S_HHB_WAIT) || (state == S_IHB_WAIT));
    assign emb_write = mem_valid && (state == S_EMB_WAIT);
    assign store = (state == S_STORE);
    assign commit = (state == S_COMMIT);

    always_comb
    begin
        case (state)
            S_IDLE, S_EMB_REQ, S_EMB_WAIT: fetch_kind = FETCH_EMBED;  // Token tracks while idle
            S_HHB_REQ, S_HHB_WAIT:         fetch_kind = FETCH_B_HH;
            S_IH_REQ, S_IH_WAIT:           fetch_kind = FETCH_W_IH;
            S_IHB_REQ, S_IHB_WAIT:         fetch_kind = FETCH_B_IH;
            default:                       fetch_kind = FETCH_W_HH;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:         if (start) next_state = S_EMB_REQ;
            S_EMB_REQ:      next_state = S_EMB_WAIT;
            S_EMB_WAIT:     if (mem_valid) next_state = emb_last ? S_NEURON_START : S_EMB_REQ;
            S_NEURON_START: next_state = S_HH_REQ;
            S_HH_REQ:       next_state = S_HH_WAIT;
            S_HH_WAIT:      if (mem_valid) next_state = hid_last ? S_HHB_REQ : S_HH_REQ;
            S_HHB_REQ:      next_state = S_HHB_WAIT;
            S_HHB_WAIT:     if (mem_valid) next_state = S_IH_REQ;
            S_IH_REQ:       next_state = S_IH_WAIT;
            S_IH_WAIT:      if (mem_valid) next_state = emb_last ? S_IHB_REQ : S_IH_REQ;
            S_IHB_REQ:      next_state = S_IHB_WAIT;
            S_IHB_WAIT:     if (mem_valid) next_state = S_STORE;
            S_STORE:        next_state = neuron_last ? S_COMMIT : S_NEURON_START;
            S_COMMIT:       next_state = S_IDLE;
            default:        next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            neuron_q <= '0;
            inner_q <= '0;
            mem_req <= 1'b0;
            done <= 1'b0;
            read_pending <= 1'b0;
        end
        else
        begin
            state <= next_state;
            mem_req <= req_state;  // Address is registered in the same cycle
            done <= (state == S_COMMIT);

            if (mem_req)
                read_pending <= 1'b1;
            else if (mem_valid)
                read_pending <= 1'b0;

            if (state == S_IDLE)
            begin
                neuron_q <= '0;
                inner_q <= '0;
            end
            else if (inner_step)
            begin
                inner_q <= ((state == S_HH_WAIT) ? hid_last : emb_last) ? '0 : inner_q + 1'b1;
            end

            if (state == S_STORE)
                neuron_q <= neuron_last ? '0 : neuron_q + 1'b1;
        end
    end

    a_one_read: assert property (@(posedge clk) disable iff (reset) mem_req |-> !read_pending)
        else $error("mem_req issued while a read is outstanding");

    // Commit only follows the store of the last neuron
    a_done_commit: assert property (@(posedge clk) disable iff (reset)
        done |-> ($past(state) == S_COMMIT) && $past(neuron_last, 2))
        else $error("done without a commit after the last neuron");

endmodule

`default_nettype wire

// File: source/rnn_cell_top.sv
`default_nettype none

module rnn_cell_top #(
    parameter int VOCAB_SIZE = rnn_pkg::DEF_VOCAB_SIZE,
    parameter int EMBED_SIZE = rnn_pkg::DEF_EMBED_SIZE,
    parameter int HIDDEN_SIZE = rnn_pkg::DEF_HIDDEN_SIZE
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [rnn_pkg::idx_width(VOCAB_SIZE)-1:0] token,
    input  logic [rnn_pkg::idx_width(HIDDEN_SIZE)-1:0] hidden_index,
    input  logic mem_valid,
    input  logic signed [rnn_pkg::DATA_WIDTH-1:0] mem_data,
    output logic busy,
    output logic done,
    output logic signed [rnn_pkg::DATA_WIDTH-1:0] hidden_value,
    output logic mem_req,
    output logic [rnn_pkg::ADDR_WIDTH-1:0] mem_addr
);
    import rnn_pkg::*;

    localparam int HID_W = idx_width(HIDDEN_SIZE);
    localparam int INNER_W = idx_width(HIDDEN_SIZE, EMBED_SIZE);

    fetch_kind_t fetch_kind;
    logic [HID_W-1:0] neuron_idx;
    logic [INNER_W-1:0] inner_idx;
    logic acc_clear;
    logic acc_mul;
    logic acc_add;
    logic emb_write;
    logic store;
    logic commit;
    logic signed [DATA_WIDTH-1:0] acc;
    logic signed [DATA_WIDTH-1:0] operand;

    rnn_control #(
        .EMBED_SIZE(EMBED_SIZE),
        .HIDDEN_SIZE(HIDDEN_SIZE)
    ) u_control (
        .clk(clk),
        .reset(reset),
        .start(start),
        .mem_valid(mem_valid),
        .busy(busy),
        .done(done),
        .mem_req(mem_req),
        .fetch_kind(fetch_kind),
        .neuron_idx(neuron_idx),
        .inner_idx(inner_idx),
        .acc_clear(acc_clear),
        .acc_mul(acc_mul),
        .acc_add(acc_add),
        .emb_write(emb_write),
        .store(store),
        .commit(commit)
    );

    weight_address_gen #(
        .VOCAB_SIZE(VOCAB_SIZE),
        .EMBED_SIZE(EMBED_SIZE),
        .HIDDEN_SIZE(HIDDEN_SIZE)
    ) u_addr_gen (
        .clk(clk),
        .reset(reset),
        .fetch_kind(fetch_kind),
        .token(token),
        .neuron_idx(neuron_idx),
        .inner_idx(inner_idx),
        .mem_addr(mem_addr)
    );

    mac_unit u_mac (
        .clk(clk),
        .reset(reset),
        .acc_clear(acc_clear),
        .acc_mul(acc_mul),
        .acc_add(acc_add),
        .mem_data(mem_data),
        .operand(operand),
        .acc(acc)
    );

    state_registers #(
        .EMBED_SIZE(EMBED_SIZE),
        .HIDDEN_SIZE(HIDDEN_SIZE)
    ) u_state (
        .clk(clk),
        .reset(reset),
        .emb_write(emb_write),
        .store(store),
        .commit(commit),
        .fetch_kind(fetch_kind),
        .neuron_idx(neuron_idx),
        .inner_idx(inner_idx),
        .mem_data(mem_data),
        .acc(acc),
        .hidden_index(hidden_index),
        .operand(operand),
        .hidden_value(hidden_value)
    );

endmodule

`default_nettype wire

// File: tb/rnn_model.svh
`ifndef RNN_MODEL_SVH
`define RNN_MODEL_SVH

logic [31:0] lfsr_state;
logic signed [DATA_WIDTH-1:0] weight_mem [MEM_WORDS];

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);  // Galois taps
endfunction

// One LFSR step per bit taken, bits collected MSB first
function automatic int unsigned take_bits(input int count);
    int unsigned value;
    int b;
    value = 0;
    for (b = 0; b < count; b++)
    begin
        lfsr_state = lfsr_next(lfsr_state);
        value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
endfunction

// Small Q8.8 values, roughly -1.0 to +1.0
function automatic void fill_weights();
    logic [8:0] raw;
    int a;
    for (a = 0; a < MEM_WORDS; a++)
    begin
        raw = 9'(take_bits(9));
        weight_mem[a] = {{7{raw[8]}}, raw};
    end
endfunction

function automatic logic signed [DATA_WIDTH-1:0] q_mul(input logic signed [DATA_WIDTH-1:0] a,
                                                       input logic signed [DATA_WIDTH-1:0] b);
    logic signed [2*DATA_WIDTH-1:0] full;
    full = a * b;
    return DATA_WIDTH'(full >>> FRAC_BITS);
endfunction

// next_h = W_hh*h + b_hh + W_ih*emb + b_ih, all wrapping at 16 bits
function automatic void model_step(input int tok);
    logic signed [DATA_WIDTH-1:0] sum;
    int i;
    int k;
    for (i = 0; i < HIDDEN_SIZE; i++)
    begin
        sum = '0;
        for (k = 0; k < HIDDEN_SIZE; k++)
            sum = sum + q_mul(weight_mem[W_HH_BASE + i * HIDDEN_SIZE + k], model_h[k]);
        sum = sum + weight_mem[B_HH_BASE + i];
        for (k = 0; k < EMBED_SIZE; k++)
            sum = sum + q_mul(weight_mem[W_IH_BASE + i * EMBED_SIZE + k],
                              weight_mem[tok * EMBED_SIZE + k]);
        sum = sum + weight_mem[B_IH_BASE + i];
        next_h[i] = sum;
    end
endfunction

`endif

// File: tb/rnn_cell_tb.sv
`default_nettype none

module rnn_cell_tb;
    import rnn_pkg::*;

    localparam int VOCAB_SIZE = DEF_VOCAB_SIZE;
    localparam int EMBED_SIZE = DEF_EMBED_SIZE;
    localparam int HIDDEN_SIZE = DEF_HIDDEN_SIZE;
    localparam int TOK_W = idx_width(VOCAB_SIZE);
    localparam int HID_W = idx_width(HIDDEN_SIZE);
    localparam int W_IH_BASE = VOCAB_SIZE * EMBED_SIZE;
    localparam int W_HH_BASE = W_IH_BASE + HIDDEN_SIZE * EMBED_SIZE;
    localparam int B_IH_BASE = W_HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int B_HH_BASE = B_IH_BASE + HIDDEN_SIZE;
    localparam int MEM_WORDS = B_HH_BASE + HIDDEN_SIZE;
    localparam int REQS_PER_STEP = EMBED_SIZE + HIDDEN_SIZE * (HIDDEN_SIZE + EMBED_SIZE + 2);
    localparam int STEP_TIMEOUT = 4000;

    logic clk;
    logic reset;
    logic start;
    logic [TOK_W-1:0] token;
    logic [HID_W-1:0] hidden_index;
    logic mem_valid;
    logic signed [DATA_WIDTH-1:0] mem_data;
    logic busy;
    logic done;
    logic signed [DATA_WIDTH-1:0] hidden_value;
    logic mem_req;
    logic [ADDR_WIDTH-1:0] mem_addr;

    logic signed [DATA_WIDTH-1:0] model_h [HIDDEN_SIZE];  // Last committed vector
    logic signed [DATA_WIDTH-1:0] next_h [HIDDEN_SIZE];
    logic [ADDR_WIDTH-1:0] exp_addr [REQS_PER_STEP];
    int total_reqs;
    int step_base;
    logic read_outstanding;
    logic [ADDR_WIDTH-1:0] req_addr;
    int delay_left;

    `include "rnn_model.svh"

    rnn_cell_top #(
        .VOCAB_SIZE(VOCAB_SIZE),
        .EMBED_SIZE(EMBED_SIZE),
        .HIDDEN_SIZE(HIDDEN_SIZE)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .start(start),
        .token(token),
        .hidden_index(hidden_index),
        .mem_valid(mem_valid),
        .mem_data(mem_data),
        .busy(busy),
        .done(done),
        .hidden_value(hidden_value),
        .mem_req(mem_req),
        .mem_addr(mem_addr)
    );

    task automatic stop_run(input string line);
        $display("TEST FAILED");
        $display("%s", line);
        $fatal(1, "simulation stopped at the first error");
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory model, answers each request after 1 to 6 cycles
    initial
    begin
        mem_valid = 1'b0;
        mem_data = '0;
        read_outstanding = 1'b0;
        total_reqs = 0;
        delay_left = 0;
        req_addr = '0;
        forever
        begin
            @(negedge clk);
            mem_valid = 1'b0;
            if (reset)
            begin
                read_outstanding = 1'b0;
            end
            else
            begin
                if (read_outstanding)
                begin
                    delay_left = delay_left - 1;
                    if (delay_left == 0)
                    begin
                        mem_valid = 1'b1;
                        mem_data = weight_mem[req_addr];
                        read_outstanding = 1'b0;
                    end
                end
                if (mem_req)
                begin
                    read_outstanding = 1'b1;
                    req_addr = mem_addr;
                    delay_left = int'(take_bits(3) % 6) + 1;
                    total_reqs = total_reqs + 1;
                end
            end
        end
    end

    readout_matches: assert property (@(posedge clk) disable iff (reset)
        hidden_value == model_h[hidden_index])
        else stop_run($sformatf("FAILED at %0t: hidden_value[%0d] is %h, expected %h",
                                $time, hidden_index, hidden_value, model_h[hidden_index]));

    addr_in_order: assert property (@(negedge clk) disable iff (reset)
        mem_req |-> (total_reqs - step_base < REQS_PER_STEP) &&
                    (mem_addr == exp_addr[total_reqs - step_base]))
        else stop_run($sformatf("FAILED at %0t: request %0d went to address %0d",
                                $time, total_reqs - step_base, mem_addr));

    one_read_at_a_time: assert property (@(negedge clk) disable iff (reset)
        mem_req |-> !read_outstanding)
        else stop_run("A memory request was issued while another read was still outstanding");

    reqs_per_step: assert property (@(posedge clk) disable iff (reset)
        done |-> (total_reqs - step_base == REQS_PER_STEP))
        else stop_run($sformatf("FAILED at %0t: step issued %0d requests, expected %0d",
                                $time, total_reqs - step_base, REQS_PER_STEP));

    done_with_busy_fall: assert property (@(posedge clk) disable iff (reset)
        done |-> $fell(busy))
        else stop_run("done was raised without busy falling in the same cycle");

    busy_fall_with_done: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> done)
        else stop_run("busy fell without a done pulse");

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else stop_run("done stayed high for more than one cycle");

    reset_clears_outputs: assert property (@(posedge clk)
        reset |=> (!busy && !done && !mem_req))
        else stop_run("busy, done or mem_req still high after reset");

    function automatic void fill_expected_requests(input int tok);
        int n;
        int i;
        int k;
        n = 0;
        for (k = 0; k < EMBED_SIZE; k++)
        begin
            exp_addr[n] = ADDR_WIDTH'(tok * EMBED_SIZE + k);
            n = n + 1;
        end
        for (i = 0; i < HIDDEN_SIZE; i++)
        begin
            for (k = 0; k < HIDDEN_SIZE; k++)
            begin
                exp_addr[n] = ADDR_WIDTH'(W_HH_BASE + i * HIDDEN_SIZE + k);
                n = n + 1;
            end
            exp_addr[n] = ADDR_WIDTH'(B_HH_BASE + i);
            n = n + 1;
            for (k = 0; k < EMBED_SIZE; k++)
            begin
                exp_addr[n] = ADDR_WIDTH'(W_IH_BASE + i * EMBED_SIZE + k);
                n = n + 1;
            end
            exp_addr[n] = ADDR_WIDTH'(B_IH_BASE + i);
            n = n + 1;
        end
    endfunction

    // Called right after a falling edge
    task automatic begin_step(input int tok);
        model_step(tok);
        fill_expected_requests(tok);
        step_base = total_reqs;
        token = TOK_W'(tok);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic finish_step();
        int n;
        for (n = 0; n < STEP_TIMEOUT && !done; n++)
        begin
            hidden_index = HID_W'(n % HIDDEN_SIZE);  // Old vector must hold until done
            @(negedge clk);
        end
        if (!done)
            stop_run("Timed out waiting for done at the end of a step");
        foreach (model_h[i])
            model_h[i] = next_h[i];
    endtask

    task automatic wait_for_requests(input int count);
        int n;
        for (n = 0; n < STEP_TIMEOUT && (total_reqs - step_base) < count; n++)
            @(negedge clk);
        if ((total_reqs - step_base) < count)
            stop_run("Timed out waiting for memory requests during a step");
    endtask

    task automatic sweep_readout();
        int i;
        for (i = 0; i < HIDDEN_SIZE; i++)
        begin
            hidden_index = HID_W'(i);
            @(negedge clk);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        token = '0;
        hidden_index = '0;
        step_base = 0;
        foreach (model_h[i])
            model_h[i] = '0;
        lfsr_state = 32'h73ea;
        fill_weights();
        repeat (8) @(negedge clk);
        reset = 1'b0;

        begin_step(5);
        finish_step();
        sweep_readout();

        begin_step(42);
        repeat (40) @(negedge clk);
        token = TOK_W'(11);  // Start while busy must be ignored
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        finish_step();
        sweep_readout();

        begin_step(75);
        finish_step();
        sweep_readout();

        begin_step(19);
        wait_for_requests(30);
        reset = 1'b1;
        foreach (model_h[i])
            model_h[i] = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        sweep_readout();

        begin_step(63);
        finish_step();
        sweep_readout();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
source/rnn_pkg.sv
source/weight_address_gen.sv
source/mac_unit.sv
source/state_registers.sv
source/rnn_control.sv
source/rnn_cell_top.sv
tb/rnn_cell_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rnn_cell_tb \
    -o rnn_cell_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rnn_cell_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
